// ==== all.f ====
design/colmix_pkg.sv
design/cpu_bus_if.sv
design/layer_stage.sv
design/prio_mux.sv
design/palette_ram.sv
design/blank_delay.sv
design/colmix_top.sv
dv/colmix_checker.sv
dv/colmix_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the colour mixer simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module colmix_tb -f all.f

status=0
./obj_dir/Vcolmix_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== dv/colmix_tb.sv ====
// ********************
// colour mixer testbench
// LFSR stimulus, reference model of PROM and palette, output checks
// ********************

`timescale 1ns/1ps

module colmix_tb;

    // test lengths in clk cycles, they set the run limit
    localparam int LEN_RST = 4;
    localparam int LEN_PAL = 48;
    localparam int LEN_MIX = 2 * 256 + 1024 + 2 * 304;
    localparam int LEN_ENA = 2 * 104;
    localparam int LEN_BLK = 2 * 204;
    localparam int LEN_RLD = 2 * 204;
    localparam int MAX_CYC = 2 * (LEN_RST + LEN_PAL + LEN_MIX + LEN_ENA + LEN_BLK + LEN_RLD);

    // one pixel strobe worth of video inputs
    typedef struct packed {
        logic            chk;
        logic [1:0]      prisel;
        logic            hbl;
        logic            vbl;
        logic [3:0]      en;
        logic [3:0][7:0] pxl;
    } smp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   pxl_cen;
    logic                   LHBL;
    logic                   LVBL;
    logic                   pal_cs;
    colmix_pkg::pal_addr_t  cpu_addr;
    logic [15:0]            cpu_dout;
    logic [1:0]             dsn;
    logic [15:0]            cpu_din;
    logic [1:0]             prisel;
    colmix_pkg::prom_addr_t prog_addr;
    colmix_pkg::sel_t       prom_din;
    logic                   prom_we;
    colmix_pkg::layer_pxl_t obj_pxl;
    colmix_pkg::layer_pxl_t ba0_pxl;
    colmix_pkg::layer_pxl_t ba1_pxl;
    colmix_pkg::layer_pxl_t ba2_pxl;
    logic [3:0]             gfx_en;
    colmix_pkg::chan8_t     red;
    colmix_pkg::chan8_t     green;
    colmix_pkg::chan8_t     blue;
    logic                   LHBL_dly;
    logic                   LVBL_dly;

    // model state, mirrors of both memories
    colmix_pkg::pal_word_t  pal_m  [colmix_pkg::PAL_WORDS];
    colmix_pkg::sel_t       prom_m [colmix_pkg::PROM_WORDS];
    colmix_pkg::pal_addr_t  addrs  [16];
    logic [26:0]            exp_q  [$];
    smp_t                   pend;
    logic                   have_pend;
    logic                   chk_on;
    logic [31:0]            lfsr;
    int                     err_cnt;
    int                     chk_cnt;
    int                     cyc = 0;
    string                  cur_test;

    colmix_top uut (.*);

    bind colmix_top colmix_checker u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .cpu_din  (cpu_din)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("cycle limit of %0d reached before the tests completed", MAX_CYC);
            $display("Finished with errors");
            $finish;
        end
    end

    // right-shift Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // n random bits, one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // PROM address: mode, bg1 bits 3 and 7, then transparency bg0, bg1, obj, bg2
    function automatic colmix_pkg::prom_addr_t prom_addr_of(input smp_t s);
        logic [3:0] op;
        for (int i = 0; i < 4; i++) begin
            op[i] = s.en[i] && (s.pxl[i][3:0] != 4'h0);
        end
        return {s.prisel, s.pxl[2][3], s.pxl[2][7], ~op[1], ~op[2], ~op[0], ~op[3]};
    endfunction

    // expected {LHBL_dly, LVBL_dly, red, green, blue} for one sample
    function automatic logic [25:0] expect_of(input smp_t s);
        logic [1:0]  lyr;
        logic [15:0] w;
        case (prom_m[prom_addr_of(s)])
            4'b1000: lyr = 2'd3;
            4'b0100: lyr = 2'd1;
            4'b0010: lyr = 2'd2;
            default: lyr = 2'd0;
        endcase
        w = pal_m[{lyr, s.pxl[lyr]}];
        // black while either blank is low
        if (!(s.hbl && s.vbl)) begin
            w = '0;
        end
        return {s.hbl, s.vbl, {2{w[3:0]}}, {2{w[7:4]}}, {2{w[11:8]}}};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act);
        chk_cnt++;
        if (act !== exp_v) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act);
        end
    endtask

    // model step on a strobe edge
    // the PROM is read for the previous sample on this edge
    task automatic strobe_done;
        smp_t        cur;
        logic [26:0] e;
        cur.chk    = chk_on;
        cur.prisel = prisel;
        cur.hbl    = LHBL;
        cur.vbl    = LVBL;
        cur.en     = gfx_en;
        cur.pxl    = {ba2_pxl, ba1_pxl, ba0_pxl, obj_pxl};
        if (have_pend) begin
            exp_q.push_back({pend.chk, expect_of(pend)});
        end
        pend      = cur;
        have_pend = 1'b1;
        // front entry was sampled four strobes ago
        if (exp_q.size() == 4) begin
            e = exp_q.pop_front();
            if (e[26]) begin
                check_val(cur_test, {6'h0, e[25:0]},
                          {6'h0, LHBL_dly, LVBL_dly, red, green, blue});
            end
        end
    endtask

    // one clk, strobe on every second edge
    task automatic tick;
        @(posedge clk);
        #2;
        if (pxl_cen) begin
            strobe_done();
        end
        pxl_cen = ~pxl_cen;
    endtask

    // write lands on a non-strobe edge
    task automatic prom_write(input colmix_pkg::prom_addr_t a, input colmix_pkg::sel_t d);
        if (pxl_cen) begin
            tick();
        end
        prog_addr = a;
        prom_din  = d;
        prom_we   = 1'b1;
        prom_m[a] = d;
        tick();
        prom_we   = 1'b0;
    endtask

    // lanes_n is active low, bit 1 the upper byte
    task automatic pal_write(input colmix_pkg::pal_addr_t a, input logic [15:0] d,
                             input logic [1:0] lanes_n);
        pal_cs   = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
        dsn      = lanes_n;
        if (!lanes_n[0]) begin
            pal_m[a][7:0] = d[7:0];
        end
        if (!lanes_n[1]) begin
            pal_m[a][15:8] = d[15:8];
        end
        tick();
        pal_cs = 1'b0;
        dsn    = 2'b11;
    endtask

    // mode 0 active video, 1 layers off, 2 random blanks, 3 PROM rewrite
    task automatic video_strobe(input int mode, input logic chk);
        if (!pxl_cen) begin
            tick();
        end
        obj_pxl = 8'(rnd(8));
        ba0_pxl = 8'(rnd(8));
        ba1_pxl = 8'(rnd(8));
        ba2_pxl = 8'(rnd(8));
        prisel  = 2'(rnd(2));
        gfx_en  = (mode == 1) ? 4'h0 : 4'(rnd(4));
        LHBL    = (mode == 2) ? 1'(rnd(1)) : 1'b1;
        LVBL    = (mode == 2) ? 1'(rnd(1)) : 1'b1;
        chk_on  = chk;
        tick();
        // new entry for the sample whose PROM read is next
        if (mode == 3) begin
            prom_write(prom_addr_of(pend), 4'(rnd(4)));
        end else begin
            tick();
        end
    endtask

    task automatic run_video(input string name, input int mode, input int n);
        int e0;
        int c0;
        e0       = err_cnt;
        c0       = chk_cnt;
        cur_test = name;
        for (int i = 0; i < n; i++) begin
            video_strobe(mode, 1'b1);
        end
        // flush the pipeline
        repeat (4) video_strobe(mode, 1'b0);
        $display("test %s finished: %0d checks, %0d errors", name, chk_cnt - c0, err_cnt - e0);
    endtask

    initial begin
        lfsr      = 32'd85028;
        rst_n     = 1'b1;
        pxl_cen   = 1'b0;
        LHBL      = 1'b0;
        LVBL      = 1'b0;
        pal_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        dsn       = 2'b11;
        prisel    = 2'b00;
        prog_addr = '0;
        prom_din  = '0;
        prom_we   = 1'b0;
        obj_pxl   = '0;
        ba0_pxl   = '0;
        ba1_pxl   = '0;
        ba2_pxl   = '0;
        gfx_en    = 4'h0;
        err_cnt   = 0;
        chk_cnt   = 0;
        have_pend = 1'b0;
        chk_on    = 1'b0;
        // PROM is cleared by reset
        for (int i = 0; i < colmix_pkg::PROM_WORDS; i++) begin
            prom_m[i] = '0;
        end
        #5 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        cur_test = "reset";
        check_val(cur_test, 32'h0, {6'h0, LHBL_dly, LVBL_dly, red, green, blue});
        check_val(cur_test, 32'h0, {16'h0, cpu_din});
        $display("test reset finished: %0d checks, %0d errors", chk_cnt, err_cnt);

        // full words first, then single-lane updates of the same words
        cur_test = "palette_access";
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 10'(rnd(10));
            pal_write(addrs[i], 16'(rnd(16)), 2'b00);
        end
        for (int i = 0; i < 16; i++) begin
            pal_write(addrs[4'(rnd(4))], 16'(rnd(16)), rnd(1) ? 2'b01 : 2'b10);
        end
        for (int i = 0; i < 16; i++) begin
            cpu_addr = addrs[i];
            tick();
            check_val(cur_test, {16'h0, pal_m[addrs[i]]}, {16'h0, cpu_din});
        end
        $display("test palette_access finished: 16 reads checked, %0d errors so far", err_cnt);

        // random PROM with non one-hot words, then a full palette
        for (int i = 0; i < colmix_pkg::PROM_WORDS; i++) begin
            prom_write(8'(i), 4'(rnd(4)));
        end
        for (int i = 0; i < colmix_pkg::PAL_WORDS; i++) begin
            pal_write(10'(i), 16'(rnd(16)), 2'b00);
        end
        run_video("priority_mix", 0, 300);
        run_video("layer_enables", 1, 100);
        run_video("blanking", 2, 200);
        run_video("prom_reload", 3, 200);

        $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== dv/colmix_checker.sv ====
// ********************
// colour mixer output assertions
// reset values, blanking black-out, nibble repeat
// ********************

`timescale 1ns/1ps

module colmix_checker (
    input logic               clk,
    input logic               rst_n,
    input colmix_pkg::chan8_t red,
    input colmix_pkg::chan8_t green,
    input colmix_pkg::chan8_t blue,
    input logic               LHBL_dly,
    input logic               LVBL_dly,
    input logic [15:0]        cpu_din
);

    // every output sits at zero while reset is low
    a_reset_zero: assert property (@(posedge clk) !rst_n |->
        (red == 8'h00 && green == 8'h00 && blue == 8'h00 &&
         !LHBL_dly && !LVBL_dly && cpu_din == 16'h0000))
        else $error("outputs not zero during reset");

    // colour and blanks leave the same register
    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (!LHBL_dly || !LVBL_dly) |-> (red == 8'h00 && green == 8'h00 && blue == 8'h00))
        else $error("colour not black during blanking");

    // 4-bit channel repeated into both nibbles
    a_nibble_rep: assert property (@(posedge clk) disable iff (!rst_n)
        red[7:4] == red[3:0] && green[7:4] == green[3:0] && blue[7:4] == blue[3:0])
        else $error("colour channel nibbles differ");

endmodule

// ==== design/colmix_top.sv ====
// ********************
// colour mixer top level
// layer stages, priority mixer, palette and blanking output
// ********************

`timescale 1ns/1ps

module colmix_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic                   LHBL,
    input  logic                   LVBL,
    // CPU palette port
    input  logic                   pal_cs,
    input  colmix_pkg::pal_addr_t  cpu_addr,
    input  logic [15:0]            cpu_dout,
    input  logic [1:0]             dsn,
    output logic [15:0]            cpu_din,
    input  logic [1:0]             prisel,
    // priority PROM load
    input  colmix_pkg::prom_addr_t prog_addr,
    input  colmix_pkg::sel_t       prom_din,
    input  logic                   prom_we,
    // layer pixels
    input  colmix_pkg::layer_pxl_t obj_pxl,
    input  colmix_pkg::layer_pxl_t ba0_pxl,
    input  colmix_pkg::layer_pxl_t ba1_pxl,
    input  colmix_pkg::layer_pxl_t ba2_pxl,
    input  logic [3:0]             gfx_en,
    output colmix_pkg::chan8_t     red,
    output colmix_pkg::chan8_t     green,
    output colmix_pkg::chan8_t     blue,
    output logic                   LHBL_dly,
    output logic                   LVBL_dly
);

    cpu_bus_if cpu_bus ();

    colmix_pkg::layer_pxl_t lyr_in  [colmix_pkg::NUM_LAYERS];
    colmix_pkg::layer_pxl_t lyr_q   [colmix_pkg::NUM_LAYERS];
    logic                   lyr_opq [colmix_pkg::NUM_LAYERS];
    colmix_pkg::pal_addr_t  pal_addr;
    colmix_pkg::pal_word_t  pal_q;

    // host side of the CPU bus
    assign cpu_bus.cs    = pal_cs;
    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.wdata = cpu_dout;
    assign cpu_bus.dsn   = dsn;
    assign cpu_din       = cpu_bus.rdata;

    // layer order follows layer_idx_t
    assign lyr_in[0] = obj_pxl;
    assign lyr_in[1] = ba0_pxl;
    assign lyr_in[2] = ba1_pxl;
    assign lyr_in[3] = ba2_pxl;

    for (genvar i = 0; i < colmix_pkg::NUM_LAYERS; i++) begin : g_layer
        layer_stage u_stage (
            .clk     (clk),
            .rst_n   (rst_n),
            .pxl_cen (pxl_cen),
            .pxl     (lyr_in[i]),
            .en      (gfx_en[i]),
            .pxl_q   (lyr_q[i]),
            .opaque  (lyr_opq[i])
        );
    end

    prio_mux u_prio (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .prisel    (prisel),
        .pxl       (lyr_q),
        .opaque    (lyr_opq),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .pal_addr  (pal_addr)
    );

    palette_ram u_pal (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .bus      (cpu_bus.ram),
        .pal_addr (pal_addr),
        .pal_q    (pal_q)
    );

    blank_delay u_blank (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .pal_q    (pal_q),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly)
    );

endmodule

// ==== design/blank_delay.sv ====
// ********************
// blanking delay and colour output
// aligns blanks with colour, expands to 8 bits, blacks out blanking
// ********************

`timescale 1ns/1ps

module blank_delay (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  LHBL,
    input  logic                  LVBL,
    input  colmix_pkg::pal_word_t pal_q,
    output colmix_pkg::chan8_t    red,
    output colmix_pkg::chan8_t    green,
    output colmix_pkg::chan8_t    blue,
    output logic                  LHBL_dly,
    output logic                  LVBL_dly
);

    localparam int SR_LEN = colmix_pkg::PIPE_DLY - 1;

    // blank shift registers, newest sample in bit 0
    logic [SR_LEN-1:0]  hbl_sr;
    logic [SR_LEN-1:0]  vbl_sr;
    logic               active;
    colmix_pkg::chan4_t r4;
    colmix_pkg::chan4_t g4;
    colmix_pkg::chan4_t b4;

    // blanks as they enter the final register
    assign active = hbl_sr[SR_LEN-1] & vbl_sr[SR_LEN-1];

    // palette channel split, upper nibble unused
    assign r4 = pal_q[3:0];
    assign g4 = pal_q[7:4];
    assign b4 = pal_q[11:8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr   <= '0;
            vbl_sr   <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hbl_sr   <= {hbl_sr[SR_LEN-2:0], LHBL};
            vbl_sr   <= {vbl_sr[SR_LEN-2:0], LVBL};
            LHBL_dly <= hbl_sr[SR_LEN-1];
            LVBL_dly <= vbl_sr[SR_LEN-1];
            // nibble repeated so full scale maps to 8'hff
            red      <= active ? {2{r4}} : '0;
            green    <= active ? {2{g4}} : '0;
            blue     <= active ? {2{b4}} : '0;
        end
    end

endmodule

// ==== design/palette_ram.sv ====
// ********************
// palette memory
// CPU byte-lane port and a video read port
// ********************

`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    cpu_bus_if.ram                bus,
    input  colmix_pkg::pal_addr_t pal_addr,
    output colmix_pkg::pal_word_t pal_q
);

    colmix_pkg::pal_word_t mem [colmix_pkg::PAL_WORDS];

    // lane write enables, dsn is active low
    logic [1:0] we;

    assign we = ~bus.dsn & {2{bus.cs}};

    // CPU writes, each enabled byte on every clk while cs is high
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[bus.addr][7:0] <= bus.wdata[7:0];
        end
        if (we[1]) begin
            mem[bus.addr][15:8] <= bus.wdata[15:8];
        end
    end

    // CPU read back, always running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rdata <= '0;
        end else begin
            bus.rdata <= mem[bus.addr];
        end
    end

    // video read, one strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_q <= '0;
        end else if (pxl_cen) begin
            pal_q <= mem[pal_addr];
        end
    end

endmodule

// ==== design/prio_mux.sv ====
// ********************
// layer priority mixer
// PROM lookup of the visible layer, builds the palette address
// ********************

`timescale 1ns/1ps

module prio_mux (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic [1:0]             prisel,
    input  colmix_pkg::layer_pxl_t pxl    [colmix_pkg::NUM_LAYERS],
    input  logic                   opaque [colmix_pkg::NUM_LAYERS],
    input  colmix_pkg::prom_addr_t prog_addr,
    input  colmix_pkg::sel_t       prom_din,
    input  logic                   prom_we,
    output colmix_pkg::pal_addr_t  pal_addr
);

    // priority PROM, run-time loadable
    colmix_pkg::sel_t       prom [colmix_pkg::PROM_WORDS];

    // priority mode aligned with the layer stage outputs
    logic [1:0]             prisel_q;
    colmix_pkg::prom_addr_t sel_addr;
    colmix_pkg::sel_t       sel_q;
    colmix_pkg::layer_idx_t sel_idx;

    // pixels held one strobe while the PROM is read
    colmix_pkg::layer_pxl_t pxl_d  [colmix_pkg::NUM_LAYERS];

    // mode comes in with the raw layer pixels
    // so it needs the same one strobe as layer_stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prisel_q <= 2'b00;
        end else if (pxl_cen) begin
            prisel_q <= prisel;
        end
    end

    // address, high to low
    // mode, bg1 bit 3, bg1 bit 7, then transparency bg0, bg1, obj, bg2
    assign sel_addr = {
        prisel_q,
        pxl[2][3],
        pxl[2][7],
        ~opaque[1],
        ~opaque[2],
        ~opaque[0],
        ~opaque[3]
    };

    // PROM contents, cleared at reset and written from the load port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < colmix_pkg::PROM_WORDS; i++) begin
                prom[i] <= '0;
            end
        end else if (prom_we) begin
            prom[prog_addr] <= prom_din;
        end
    end

    // registered PROM read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (pxl_cen) begin
            sel_q <= prom[sel_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl_d <= pxl;
        end
    end

    // one-hot decode, anything not matching falls back to objects
    always_comb begin
        case (sel_q)
            4'd8:    sel_idx = 2'd3;
            4'd4:    sel_idx = 2'd1;
            4'd2:    sel_idx = 2'd2;
            default: sel_idx = 2'd0;
        endcase
    end

    // palette address, layer number on top of its pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= {sel_idx, pxl_d[sel_idx]};
        end
    end

endmodule

// ==== design/layer_stage.sv ====
// ********************
// layer input stage
// registers one layer pixel and its opaque flag
// ********************

`timescale 1ns/1ps

module layer_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  colmix_pkg::layer_pxl_t pxl,
    input  logic                   en,
    output colmix_pkg::layer_pxl_t pxl_q,
    output logic                   opaque
);

    // colour index zero means see-through
    logic idx_nz;

    assign idx_nz = |pxl[3:0];

    // pixel payload, advances on the strobe only
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl_q <= pxl;
        end
    end

    // opaque flag
    // a disabled layer is always treated as transparent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opaque <= 1'b0;
        end else if (pxl_cen) begin
            opaque <= en & idx_nz;
        end
    end

endmodule

// ==== design/cpu_bus_if.sv ====
// ********************
// CPU palette access bus
// word address, write data, byte enables, read data
// ********************

`timescale 1ns/1ps

interface cpu_bus_if;

    // chip select, level sensitive, no handshake
    logic                  cs;
    // palette word address
    colmix_pkg::pal_addr_t addr;
    colmix_pkg::pal_word_t wdata;
    // active-low byte enables, bit 1 is the upper byte
    logic [1:0]            dsn;
    // registered read, one clk after addr
    colmix_pkg::pal_word_t rdata;

    modport host (
        output cs,
        output addr,
        output wdata,
        output dsn,
        input  rdata
    );

    modport ram (
        input  cs,
        input  addr,
        input  wdata,
        input  dsn,
        output rdata
    );

endinterface

// ==== design/colmix_pkg.sv ====
// ********************
// colour mixer shared definitions
// widths, layer count and video pipeline depth
// ********************

package colmix_pkg;

    // number of graphics layers feeding the mixer
    localparam int NUM_LAYERS = 4;

    // pixel strobes from layer input to colour output
    // also the depth of the blanking delay
    localparam int PIPE_DLY = 5;

    // memory depths
    localparam int PAL_WORDS  = 1024;
    localparam int PROM_WORDS = 256;

    // layer pixel, low nibble is the colour index (0 = transparent)
    // upper nibble carries palette sub-bank and attributes
    typedef logic [7:0] layer_pxl_t;

    // layer number, 0 objects, 1 bg0, 2 bg1, 3 bg2
    typedef logic [1:0] layer_idx_t;

    // palette address, layer number above the pixel
    typedef logic [9:0] pal_addr_t;

    // palette word, red 3:0, green 7:4, blue 11:8, 15:12 unused
    typedef logic [15:0] pal_word_t;

    // priority PROM address and one-hot layer choice
    typedef logic [7:0] prom_addr_t;
    typedef logic [3:0] sel_t;

    // colour channels before and after expansion
    typedef logic [3:0] chan4_t;
    typedef logic [7:0] chan8_t;

endpackage
